/* hdl/rv_exec_macros.svh */
// Word width and register count for the RV32I execute stage; RV_NREGS must stay 32 (5-bit indices)
`ifndef RV_EXEC_MACROS_SVH
`define RV_EXEC_MACROS_SVH

// Data word width in bits
`define RV_XLEN 32

// Architectural integer registers
// x0 included
`define RV_NREGS 32

`endif

/* hdl/rv_exec_pkg.sv */
// RV32I execute types and encodings; only the formats and opcodes of the supported subset are defined
`include "rv_exec_macros.svh"

package rv_exec_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          reg_idx_t;
    typedef logic [3:0]          alu_op_t;
    typedef logic [2:0]          br_kind_t;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // ALU operations
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // Branch kinds equal funct3
    // 3'b010 is free in funct3, so it marks no branch
    localparam br_kind_t BR_EQ   = 3'b000;
    localparam br_kind_t BR_NE   = 3'b001;
    localparam br_kind_t BR_NONE = 3'b010;
    localparam br_kind_t BR_LT   = 3'b100;
    localparam br_kind_t BR_GE   = 3'b101;
    localparam br_kind_t BR_LTU  = 3'b110;
    localparam br_kind_t BR_GEU  = 3'b111;

    // ALU operand selects
    localparam logic [1:0] A_RS1  = 2'd0;
    localparam logic [1:0] A_PC   = 2'd1;
    localparam logic [1:0] B_RS2  = 2'd0;
    localparam logic [1:0] B_IMM  = 2'd1;
    localparam logic [1:0] B_FOUR = 2'd2;

    // One instruction word, seen in each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7; reg_idx_t rs2; reg_idx_t rs1;
            logic [2:0] funct3; reg_idx_t rd;  logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm11_0; reg_idx_t rs1; logic [2:0] funct3;
            reg_idx_t rd; logic [6:0] opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm11_5; reg_idx_t rs2; reg_idx_t rs1;
            logic [2:0] funct3; logic [4:0] imm4_0; logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic imm12; logic [5:0] imm10_5; reg_idx_t rs2; reg_idx_t rs1;
            logic [2:0] funct3; logic [3:0] imm4_1; logic imm11; logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm31_12; reg_idx_t rd; logic [6:0] opcode;
        } u_fmt;
        struct packed {
            logic imm20; logic [9:0] imm10_1; logic imm11; logic [7:0] imm19_12;
            reg_idx_t rd; logic [6:0] opcode;
        } j_fmt;
    } instr_u;

endpackage

/* hdl/rv_decode.sv */
// RV32I decoder for ALU, LUI, AUIPC, JAL, JALR and branches; loads, stores, CSRs and RV32M/C flag illegal
`timescale 1ns/10ps

module rv_decode (
    input  rv_exec_pkg::instr_u   instr,
    output rv_exec_pkg::reg_idx_t rs1,
    output rv_exec_pkg::reg_idx_t rs2,
    output rv_exec_pkg::reg_idx_t rd,
    output rv_exec_pkg::alu_op_t  alu_op,
    output logic [1:0]            a_sel,
    output logic [1:0]            b_sel,
    output rv_exec_pkg::word_t    imm,
    output rv_exec_pkg::br_kind_t br_kind,
    output logic                  jal,
    output logic                  jalr,
    output logic                  reg_write,
    output logic                  illegal
);

    import rv_exec_pkg::*;

    word_t      imm_i, imm_u, imm_b, imm_j;
    logic [2:0] f3;
    logic [6:0] f7;

    // funct3 to ALU op, alt picks SUB / SRA
    function automatic alu_op_t f3_to_op(input logic [2:0] fn3, input logic alt);
        alu_op_t op;
        case (fn3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // Fields common to all formats
    assign f3  = instr.r_fmt.funct3;
    // Same bits as the shift-immediate upper field
    assign f7  = instr.r_fmt.funct7;
    assign rs1 = instr.i_fmt.rs1;
    // rs2 sits at the same place in R, S and B
    assign rs2 = instr.s_fmt.rs2;
    assign rd  = instr.r_fmt.rd;

    // Sign-extended immediates
    assign imm_i = {{20{instr.i_fmt.imm11_0[11]}}, instr.i_fmt.imm11_0};
    assign imm_u = {instr.u_fmt.imm31_12, 12'b0};
    assign imm_b = {{20{instr.b_fmt.imm12}}, instr.b_fmt.imm11, instr.b_fmt.imm10_5,
                    instr.b_fmt.imm4_1, 1'b0};
    assign imm_j = {{12{instr.j_fmt.imm20}}, instr.j_fmt.imm19_12, instr.j_fmt.imm11,
                    instr.j_fmt.imm10_1, 1'b0};

    always_comb begin
        alu_op    = ALU_ADD;
        a_sel     = A_RS1;
        b_sel     = B_RS2;
        imm       = '0;
        br_kind   = BR_NONE;
        jal       = 1'b0;
        jalr      = 1'b0;
        reg_write = 1'b0;
        illegal   = 1'b0;
        case (instr.r_fmt.opcode)
            OPC_OP: begin
                reg_write = 1'b1;
                alu_op    = f3_to_op(f3, f7[5]);
                // Only ADD/SUB and SRL/SRA have an alternate funct7
                illegal   = !((f7 == 7'b0) ||
                              (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)));
            end
            OPC_OP_IMM: begin
                reg_write = 1'b1;
                b_sel     = B_IMM;
                imm       = imm_i;
                alu_op    = f3_to_op(f3, (f3 == 3'b101) && f7[5]);
                // Shift immediates constrain the upper seven bits
                if (f3 == 3'b001) begin
                    illegal = (f7 != 7'b0);
                end else if (f3 == 3'b101) begin
                    illegal = (f7 != 7'b0) && (f7 != 7'b0100000);
                end
            end
            OPC_LUI: begin
                reg_write = 1'b1;
                b_sel     = B_IMM;
                imm       = imm_u;
                alu_op    = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                reg_write = 1'b1;
                a_sel     = A_PC;
                b_sel     = B_IMM;
                imm       = imm_u;
            end
            OPC_JAL: begin
                // Link value pc+4 through the ALU
                reg_write = 1'b1;
                jal       = 1'b1;
                a_sel     = A_PC;
                b_sel     = B_FOUR;
                imm       = imm_j;
            end
            OPC_JALR: begin
                reg_write = 1'b1;
                jalr      = 1'b1;
                a_sel     = A_PC;
                b_sel     = B_FOUR;
                imm       = imm_i;
                illegal   = (f3 != 3'b000);
            end
            OPC_BRANCH: begin
                imm     = imm_b;
                br_kind = f3;
                // funct3 010 and 011 are not branches
                illegal = (f3 == 3'b010) || (f3 == 3'b011);
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

/* hdl/rv_reg_file.sv */
// Integer register file, two combinational reads and one write; x0 reads zero, no write-to-read bypass
`timescale 1ns/10ps
`include "rv_exec_macros.svh"

module rv_reg_file (
    input  logic                  CLK,
    input  logic                  nRST,
    input  rv_exec_pkg::reg_idx_t rs1,
    input  rv_exec_pkg::reg_idx_t rs2,
    output rv_exec_pkg::word_t    rs1_data,
    output rv_exec_pkg::word_t    rs2_data,
    input  logic                  wen,
    input  rv_exec_pkg::reg_idx_t rd,
    input  rv_exec_pkg::word_t    w_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    // Architectural state clears on reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            regs <= '{default: '0};
        end else if (wen && (rd != '0)) begin
            // x0 never written
            regs[rd] <= w_data;
        end
    end

    // Reads see the write only after the edge
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // x0 holds zero through any write sequence
    x0_zero_a: assert property (
        @(posedge CLK) disable iff (!nRST)
        (rs1 == '0) |-> (rs1_data == '0)
    );

endmodule

/* hdl/rv_alu.sv */
// RV32I integer ALU, purely combinational; shifts use only the low five bits of port_b
`timescale 1ns/10ps

module rv_alu (
    input  rv_exec_pkg::alu_op_t alu_op,
    input  rv_exec_pkg::word_t   port_a,
    input  rv_exec_pkg::word_t   port_b,
    output rv_exec_pkg::word_t   port_out
);

    import rv_exec_pkg::*;

    logic [4:0] shamt;

    assign shamt = port_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    port_out = port_a + port_b;
            ALU_SUB:    port_out = port_a - port_b;
            ALU_SLL:    port_out = port_a << shamt;
            // Compare results are zero-extended flags
            ALU_SLT:    port_out = word_t'($signed(port_a) < $signed(port_b));
            ALU_SLTU:   port_out = word_t'(port_a < port_b);
            ALU_XOR:    port_out = port_a ^ port_b;
            ALU_SRL:    port_out = port_a >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:    port_out = word_t'($signed(port_a) >>> shamt);
            ALU_OR:     port_out = port_a | port_b;
            ALU_AND:    port_out = port_a & port_b;
            // LUI path
            ALU_PASS_B: port_out = port_b;
            default:    port_out = '0;
        endcase
    end

endmodule

/* hdl/rv_branch_unit.sv */
// Branch resolution and next-pc choice; expects forwarded operands and no prediction, JALR clears bit 0
`timescale 1ns/10ps

module rv_branch_unit (
    input  rv_exec_pkg::br_kind_t br_kind,
    input  logic                  jal,
    input  logic                  jalr,
    input  rv_exec_pkg::word_t    rs1_data,
    input  rv_exec_pkg::word_t    rs2_data,
    input  rv_exec_pkg::word_t    pc,
    input  rv_exec_pkg::word_t    imm,
    output logic                  branch_taken,
    output rv_exec_pkg::word_t    brj_addr
);

    import rv_exec_pkg::*;

    word_t jalr_sum;

    // Condition per funct3
    always_comb begin
        case (br_kind)
            BR_EQ:   branch_taken = (rs1_data == rs2_data);
            BR_NE:   branch_taken = (rs1_data != rs2_data);
            BR_LT:   branch_taken = ($signed(rs1_data) < $signed(rs2_data));
            BR_GE:   branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
            BR_LTU:  branch_taken = (rs1_data < rs2_data);
            BR_GEU:  branch_taken = (rs1_data >= rs2_data);
            // BR_NONE and reserved codes
            default: branch_taken = 1'b0;
        endcase
    end

    assign jalr_sum = rs1_data + imm;

    // Next address
    always_comb begin
        if (jalr) begin
            brj_addr = {jalr_sum[31:1], 1'b0};
        end else if (jal || branch_taken) begin
            brj_addr = pc + imm;
        end else begin
            // Fall-through
            brj_addr = pc + 32'd4;
        end
    end

endmodule

/* hdl/rv_execute_stage.sv */
// RV32I execute stage with one-cycle ex/mem register; stall beats flush, no loads/stores or traps
`timescale 1ns/10ps

module rv_execute_stage (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  in_valid,
    input  logic                  stall,
    input  logic                  flush,
    input  rv_exec_pkg::word_t    in_pc,
    input  rv_exec_pkg::instr_u   in_instr,
    output logic                  mem_valid,
    output logic                  mem_reg_write,
    output logic                  mem_branch_taken,
    output logic                  mem_jump,
    output logic                  mem_illegal,
    output rv_exec_pkg::reg_idx_t mem_rd,
    output rv_exec_pkg::word_t    mem_pc,
    output rv_exec_pkg::word_t    mem_result,
    output rv_exec_pkg::word_t    mem_brj_addr
);

    import rv_exec_pkg::*;

    reg_idx_t   rs1, rs2, rd;
    alu_op_t    alu_op;
    logic [1:0] a_sel, b_sel;
    word_t      imm, rs1_rf, rs2_rf, rs1_fwd, rs2_fwd;
    word_t      port_a, port_b, alu_out, brj_addr;
    br_kind_t   br_kind;
    logic       jal, jalr, reg_write, illegal, branch_taken;
    logic       fwd_ok, live, ok;

    rv_decode dec_i (
        .instr(in_instr), .rs1, .rs2, .rd, .alu_op, .a_sel, .b_sel, .imm,
        .br_kind, .jal, .jalr, .reg_write, .illegal
    );

    // Writeback from ex/mem, held off while stalled
    rv_reg_file rf_i (
        .CLK, .nRST, .rs1, .rs2, .rs1_data(rs1_rf), .rs2_data(rs2_rf),
        .wen(mem_valid && mem_reg_write && !stall), .rd(mem_rd), .w_data(mem_result)
    );

    // Forward from ex/mem when it will write a non-zero rd
    assign fwd_ok  = mem_valid && mem_reg_write && (mem_rd != '0);
    assign rs1_fwd = (fwd_ok && mem_rd == rs1) ? mem_result : rs1_rf;
    assign rs2_fwd = (fwd_ok && mem_rd == rs2) ? mem_result : rs2_rf;

    // Operand muxes
    assign port_a = (a_sel == A_PC) ? in_pc : rs1_fwd;
    always_comb begin
        case (b_sel)
            B_RS2:   port_b = rs2_fwd;
            B_IMM:   port_b = imm;
            B_FOUR:  port_b = 32'd4;
            default: port_b = '0;
        endcase
    end

    rv_alu alu_i (.alu_op, .port_a, .port_b, .port_out(alu_out));

    rv_branch_unit br_i (
        .br_kind, .jal, .jalr, .rs1_data(rs1_fwd), .rs2_data(rs2_fwd),
        .pc(in_pc), .imm, .branch_taken, .brj_addr
    );

    // Valid, unflushed slot; ok also drops illegal side effects
    assign live = in_valid && !flush;
    assign ok   = live && !illegal;

    // Control half of ex/mem
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mem_valid        <= 1'b0;
            mem_reg_write    <= 1'b0;
            mem_branch_taken <= 1'b0;
            mem_jump         <= 1'b0;
            mem_illegal      <= 1'b0;
        end else if (!stall) begin
            mem_valid        <= live;
            mem_reg_write    <= ok && reg_write;
            mem_branch_taken <= ok && branch_taken;
            mem_jump         <= ok && (jal || jalr);
            mem_illegal      <= live && illegal;
        end
    end

    // Payload half, zeroed on flush
    always_ff @(posedge CLK) begin
        if (!stall) begin
            mem_rd       <= flush ? '0 : rd;
            mem_pc       <= flush ? '0 : in_pc;
            mem_result   <= flush ? '0 : alu_out;
            mem_brj_addr <= flush ? '0 : brj_addr;
        end
    end

    wr_needs_valid_a: assert property (
        @(posedge CLK) disable iff (!nRST) mem_reg_write |-> mem_valid
    );

    // Whole ex/mem content frozen across a stalled edge
    stall_hold_a: assert property (
        @(posedge CLK) disable iff (!nRST)
        stall |=> $stable({mem_valid, mem_reg_write, mem_branch_taken, mem_jump,
                           mem_illegal, mem_rd, mem_pc, mem_result, mem_brj_addr})
    );

endmodule

/* bench/rv_exec_tb.sv */
// Random RV32I bench on x0-x7 against a pc-free ISA model; runs 2000 instructions and stops at the first mismatch
`timescale 1ns/10ps
`include "rv_exec_macros.svh"

module rv_exec_tb;

    import rv_exec_pkg::*;

    logic        CLK;
    logic        nRST;
    logic        in_valid, stall, flush;
    word_t       in_pc;
    instr_u      in_instr;
    logic        mem_valid, mem_reg_write, mem_branch_taken, mem_jump, mem_illegal;
    reg_idx_t    mem_rd;
    word_t       mem_pc, mem_result, mem_brj_addr;

    // Architectural registers in program order
    word_t       arch_regs [`RV_NREGS];
    logic [31:0] rng_state, knob;
    // Expected ex/mem content
    logic        e_valid, e_wr, e_taken, e_jump, e_illegal;
    reg_idx_t    e_rd;
    word_t       e_pc, e_res, e_addr;
    // Which payload fields carry a defined value
    logic        chk_id, chk_res, chk_addr;
    // Instruction held by the source until accepted
    logic        pending, cur_valid;
    word_t       cur_pc;
    logic [31:0] cur_instr;
    int          n_done, n_cycles;

    rv_execute_stage dut_i (.*);

    always #10 CLK = ~CLK;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        // Better-mixed upper half moved low
        return {rng_state[15:0], rng_state[31:16]};
    endfunction

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("Error %s expected %h got %h", name, exp, got);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic run_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else value_error(name, exp, got);
    endtask

    // RV32I integer operations by funct3
    function automatic word_t isa_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        logic signed [31:0] sa;
        sa = a;
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                // SRA keeps the sign bit
                if (alt) begin
                    return sa >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Reference for one instruction on the current architectural state
    task automatic model_exec(input logic [31:0] w, input word_t pc, output logic legal,
                              output logic wr, output logic jump, output logic taken,
                              output word_t res, output word_t addr);
        word_t      a, b, imm_i, imm_u, imm_b, imm_j;
        logic [2:0] f3;
        logic [6:0] f7;
        a     = arch_regs[w[19:15]];
        b     = arch_regs[w[24:20]];
        f3    = w[14:12];
        f7    = w[31:25];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_u = {w[31:12], 12'b0};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        legal = 1'b1;
        wr    = 1'b0;
        jump  = 1'b0;
        taken = 1'b0;
        res   = '0;
        addr  = pc + 32'd4;
        case (w[6:0])
            OPC_OP: begin
                legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                wr    = 1'b1;
                res   = isa_alu(f3, f7[5], a, b);
            end
            OPC_OP_IMM: begin
                // Shift immediates restrict imm[11:5]
                if (f3 == 3'd1) begin
                    legal = (f7 == 7'h00);
                end else if (f3 == 3'd5) begin
                    legal = (f7 == 7'h00) || (f7 == 7'h20);
                end
                wr  = 1'b1;
                res = isa_alu(f3, (f3 == 3'd5) && f7[5], a, imm_i);
            end
            OPC_LUI: begin
                wr  = 1'b1;
                res = imm_u;
            end
            OPC_AUIPC: begin
                wr  = 1'b1;
                res = pc + imm_u;
            end
            OPC_JAL: begin
                wr   = 1'b1;
                jump = 1'b1;
                res  = pc + 32'd4;
                addr = pc + imm_j;
            end
            OPC_JALR: begin
                legal = (f3 == 3'd0);
                wr    = 1'b1;
                jump  = 1'b1;
                res   = pc + 32'd4;
                addr  = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    3'd7: taken = (a >= b);
                    default: legal = 1'b0;
                endcase
                if (taken) begin
                    addr = pc + imm_b;
                end
            end
            default: legal = 1'b0;
        endcase
        // Illegal words leave no side effects
        if (!legal) begin
            wr    = 1'b0;
            jump  = 1'b0;
            taken = 1'b0;
        end
    endtask

    // Random word from the kept subset on a small register range for frequent hazards
    function automatic logic [31:0] gen_instr();
        logic [31:0] r, s;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3, bf3;
        logic [6:0]  f7;
        logic [11:0] imm;
        r   = lcg_next();
        s   = lcg_next();
        rd  = {2'b0, r[2:0]};
        rs1 = {2'b0, r[5:3]};
        rs2 = {2'b0, r[8:6]};
        f3  = r[11:9];
        // About one in sixteen illegal
        if (r[15:12] == 4'd0) begin
            case (s[1:0])
                // Load opcode
                2'd0: return {s[31:20], rs1, f3, rd, 7'b0000011};
                // RV32M funct7
                2'd1: return {7'b0000001, rs2, rs1, f3, rd, OPC_OP};
                2'd2: return {s[31:25], rs2, rs1, {2'b01, s[2]}, s[11:7], OPC_BRANCH};
                default: return {s[31:20], rs1, f3 | 3'b001, rd, OPC_JALR};
            endcase
        end
        case (s[30:28])
            3'd0, 3'd7: begin
                // SUB and SRA half the time
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && s[4]) ? 7'h20 : 7'h00;
                return {f7, rs2, rs1, f3, rd, OPC_OP};
            end
            3'd1: begin
                imm = s[15:4];
                if (f3 == 3'd1) begin
                    imm[11:5] = 7'h00;
                end else if (f3 == 3'd5) begin
                    imm[11:5] = s[3] ? 7'h20 : 7'h00;
                end
                return {imm, rs1, f3, rd, OPC_OP_IMM};
            end
            3'd2: return {s[23:4], rd, OPC_LUI};
            3'd3: return {s[23:4], rd, OPC_AUIPC};
            3'd4: return {s[23:4], rd, OPC_JAL};
            3'd5: return {s[15:4], rs1, 3'b000, rd, OPC_JALR};
            default: begin
                // 010 and 011 folded onto 100 and 101
                bf3 = (f3[2:1] == 2'b01) ? {2'b10, f3[0]} : f3;
                return {s[31:25], rs2, rs1, bf3, s[11:7], OPC_BRANCH};
            end
        endcase
    endfunction

    // ex/mem content expected after the coming rising edge
    task automatic predict_edge();
        logic  legal, wr, jump, taken;
        word_t res, addr;
        // Stall freezes ex/mem and the register file even under flush
        if (stall) begin
            return;
        end
        model_exec(cur_instr, cur_pc, legal, wr, jump, taken, res, addr);
        e_valid   = cur_valid && !flush;
        e_wr      = e_valid && wr;
        e_taken   = e_valid && taken;
        e_jump    = e_valid && jump;
        e_illegal = e_valid && !legal;
        // Flush loads a zero payload
        e_rd      = flush ? '0 : cur_instr[11:7];
        e_pc      = flush ? '0 : cur_pc;
        e_res     = flush ? '0 : res;
        e_addr    = flush ? '0 : addr;
        chk_id    = flush || e_valid;
        chk_res   = flush || (e_valid && legal && cur_instr[6:0] != OPC_BRANCH);
        chk_addr  = flush || (e_valid && legal);
        // x0 never written
        if (e_wr && e_rd != '0) begin
            arch_regs[e_rd] = res;
        end
        if (cur_valid) begin
            n_done++;
        end
        pending = 1'b0;
    endtask

    task automatic check_outputs();
        check_val("mem_valid", e_valid, mem_valid);
        check_val("mem_reg_write", e_wr, mem_reg_write);
        check_val("mem_branch_taken", e_taken, mem_branch_taken);
        check_val("mem_jump", e_jump, mem_jump);
        check_val("mem_illegal", e_illegal, mem_illegal);
        if (chk_id) begin
            check_val("mem_rd", e_rd, mem_rd);
            check_val("mem_pc", e_pc, mem_pc);
        end
        if (chk_res) begin
            check_val("mem_result", e_res, mem_result);
        end
        if (chk_addr) begin
            check_val("mem_brj_addr", e_addr, mem_brj_addr);
        end
    endtask

    // Wait for an empty pipeline within a cycle bound
    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (mem_valid || mem_reg_write) begin
            @(negedge CLK);
            n++;
            if (n > 16) begin
                run_error({"Timeout: pipeline did not go idle ", what});
            end
        end
    endtask

    initial begin
        CLK       = 1'b0;
        nRST      = 1'b0;
        in_valid  = 1'b0;
        stall     = 1'b0;
        flush     = 1'b0;
        in_pc     = '0;
        in_instr  = '0;
        rng_state = 32'h4c82;
        arch_regs = '{default: '0};
        {e_valid, e_wr, e_taken, e_jump, e_illegal} = '0;
        {chk_id, chk_res, chk_addr} = '0;
        e_rd      = '0;
        e_pc      = '0;
        e_res     = '0;
        e_addr    = '0;
        pending   = 1'b0;
        cur_valid = 1'b0;
        cur_pc    = '0;
        cur_instr = '0;
        n_done    = 0;
        n_cycles  = 0;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        check_val("mem_valid", 32'd0, mem_valid);
        check_val("mem_reg_write", 32'd0, mem_reg_write);
        while (n_done < 2000) begin
            if (!pending) begin
                cur_instr = gen_instr();
                knob      = lcg_next();
                cur_pc    = {knob[31:2], 2'b00};
                // Occasional bubble
                cur_valid = (knob[1:0] != 2'd0) || knob[5];
                pending   = 1'b1;
            end
            knob     = lcg_next();
            stall    = (knob[2:0] == 3'd0);
            flush    = (knob[5:3] == 3'd0);
            in_valid = cur_valid;
            in_pc    = cur_pc;
            in_instr = cur_instr;
            predict_edge();
            @(negedge CLK);
            check_outputs();
            n_cycles++;
            if (n_cycles > 20000) begin
                run_error("Timeout: the stage accepted too few instructions");
            end
        end
        // Drain the last instruction
        in_valid = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        wait_idle("at the end of the run");
        $display("TB PASSED");
        $finish;
    end

endmodule

/* rv_execute_stage.f */
+incdir+hdl
hdl/rv_exec_pkg.sv
hdl/rv_decode.sv
hdl/rv_reg_file.sv
hdl/rv_alu.sv
hdl/rv_branch_unit.sv
hdl/rv_execute_stage.sv
bench/rv_exec_tb.sv

/* Makefile */
# Verilator build and run of the execute stage testbench
TOP = rv_exec_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f rv_execute_stage.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; echo "$$out" | grep -q "^TB PASSED$$"

lint:
	verilator --lint-only --timing -f rv_execute_stage.f --top-module rv_execute_stage

clean:
	rm -rf obj_dir
